/* rtl/srio_db_config.svh */
// Shared constants for the SRIO doorbell and NWRITE request engine
// Packet format and transaction type codes, request priority
// Doorbell info values for self-check, replies and data integration
// Response wait limit and timer width

`ifndef SRIO_DB_CONFIG_SVH
`define SRIO_DB_CONFIG_SVH

// Packet format codes
`define SRIO_FTYPE_DOORB 4'hA
`define SRIO_FTYPE_NWR 4'h5

// NWRITE transaction type
`define SRIO_TTYPE_NWR 4'h4

// Priority used on every request
`define SRIO_REQ_PRIO 2'd1

// Doorbell info values
`define DB_INFO_SELF 16'h0101
`define DB_INFO_READY 16'h0100
`define DB_INFO_BUSY 16'h01FF
`define DB_INFO_INTEG_BASE 16'h0200

// Only replies from this device are taken
`define DB_RESP_SRC_ID 16'h00F0

// Base address of target 1, 1 MiB
`define TARGET_ADDR_STEP 34'h0_0010_0000

// Response wait limit in log_clk cycles
`define DB_TIMEOUT_CYCLES 1024
`define DB_TIMER_W 11

`endif

/* rtl/srio_pkt_pkg.sv */
// Types for SRIO packet fields and stream beats
// Device IDs, packet codes, transaction ID, doorbell info,
// address, NWRITE size and the 64-bit stream beat fields

`default_nettype none

package srio_pkt_pkg;

    // Packet header fields
    typedef logic [15:0] dev_id_t;
    typedef logic [3:0]  ftype_t;
    typedef logic [3:0]  ttype_t;
    typedef logic [7:0]  tid_t;
    typedef logic [15:0] db_info_t;
    typedef logic [33:0] srio_addr_t;

    // Byte count minus one
    typedef logic [7:0]  nwr_size_t;

    // Stream beat fields
    typedef logic [63:0] beat_data_t;
    typedef logic [7:0]  beat_keep_t;

    // Source ID in the upper half, destination ID in the lower half
    typedef logic [31:0] beat_user_t;

endpackage

`default_nettype wire

/* rtl/db_ctrl_pkg.sv */
// Types for the transaction controller
// Controller states, request kinds and error codes

`default_nettype none

package db_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE, DB_REQ, DB_RESP, NWR, INTEG_REQ, WAIT_ACK
    } db_state_t;

    // Packet the builder is asked to send
    typedef enum logic [1:0] {
        REQ_DB_SELF, REQ_NWR, REQ_DB_INTEG
    } req_kind_t;

    typedef enum logic [1:0] {
        ERR_NONE = 2'd0, ERR_NO_DB_RESP = 2'd1, ERR_NO_INTEG_ACK = 2'd2
    } db_err_t;

endpackage

`default_nettype wire

/* rtl/ireq_builder.sv */
// Request stream builder
// Forms self-check and integration doorbell beats and NWRITE packets
// (header beat plus user beats passed through) on the outgoing stream

`timescale 1ns/1ps
`default_nettype none

`include "srio_db_config.svh"

module ireq_builder
    import srio_pkt_pkg::*;
    import db_ctrl_pkg::*;
(
    input  wire logic       log_clk,
    input  wire logic       log_rst,

    input  wire logic       req_start_i,
    input  wire req_kind_t  req_kind_i,
    output logic            req_done_o,

    input  wire dev_id_t    src_id_i,
    input  wire dev_id_t    des_id_i,
    input  wire nwr_size_t  nwr_size_i,
    input  wire logic       target_sel_i,

    input  wire beat_data_t user_tdata_i,
    input  wire beat_keep_t user_tkeep_i,
    input  wire logic       user_tvalid_i,
    input  wire logic       user_tlast_i,
    output logic            user_tready_o,

    output logic            ireq_tvalid_o,
    input  wire logic       ireq_tready_i,
    output beat_data_t      ireq_tdata_o,
    output beat_keep_t      ireq_tkeep_o,
    output logic            ireq_tlast_o,
    output beat_user_t      ireq_tuser_o
);

    typedef enum logic [1:0] {PH_IDLE, PH_HEADER, PH_DATA} phase_t;

    phase_t     phase_q;
    tid_t       tid;
    db_info_t   db_info;
    srio_addr_t nwr_addr;
    beat_data_t db_beat;
    beat_data_t nwr_beat;
    logic       out_xfer;
    logic       user_take;

    // Target select picks TID, address and integration info
    assign tid      = {7'h00, target_sel_i};
    assign nwr_addr = target_sel_i ? `TARGET_ADDR_STEP : '0;
    assign db_info  = (req_kind_i == REQ_DB_SELF) ? `DB_INFO_SELF :
                      `DB_INFO_INTEG_BASE + {15'h0000, ~target_sel_i};

    // TID, FTYPE, reserved, prio, CRF, reserved, info, reserved
    assign db_beat = {tid, `SRIO_FTYPE_DOORB, 4'h0, 1'b0, `SRIO_REQ_PRIO, 1'b0,
                      12'h000, db_info, 16'h0000};

    // TID, FTYPE, TTYPE, reserved, prio, CRF, size, reserved, address
    assign nwr_beat = {tid, `SRIO_FTYPE_NWR, `SRIO_TTYPE_NWR, 1'b0, `SRIO_REQ_PRIO,
                       1'b0, nwr_size_i, 2'b00, nwr_addr};

    assign out_xfer   = ireq_tvalid_o && ireq_tready_i;
    assign req_done_o = out_xfer && ireq_tlast_o;

    // Take a user beat when the slot is empty or draining, but never
    // after the last beat of the packet is already held
    assign user_tready_o = (phase_q == PH_DATA) &&
                           (!ireq_tvalid_o || (ireq_tready_i && !ireq_tlast_o));
    assign user_take     = user_tready_o && user_tvalid_i;

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            phase_q       <= PH_IDLE;
            ireq_tvalid_o <= 1'b0;
        end else begin
            case (phase_q)
                PH_IDLE: begin
                    if (req_start_i) begin
                        ireq_tvalid_o <= 1'b1;
                        phase_q       <= PH_HEADER;
                    end
                end
                PH_HEADER: begin
                    // A doorbell ends here, an NWRITE moves on to data
                    if (out_xfer) begin
                        ireq_tvalid_o <= 1'b0;
                        phase_q       <= ireq_tlast_o ? PH_IDLE : PH_DATA;
                    end
                end
                PH_DATA: begin
                    if (user_take) begin
                        ireq_tvalid_o <= 1'b1;
                    end else if (out_xfer) begin
                        ireq_tvalid_o <= 1'b0;
                    end
                    if (out_xfer && ireq_tlast_o) begin
                        phase_q <= PH_IDLE;
                    end
                end
                default: begin
                    ireq_tvalid_o <= 1'b0;
                    phase_q       <= PH_IDLE;
                end
            endcase
        end
    end

    // Beat payload, loaded on start or on a user beat and held otherwise
    always_ff @(posedge log_clk) begin
        if (phase_q == PH_IDLE && req_start_i) begin
            ireq_tdata_o <= (req_kind_i == REQ_NWR) ? nwr_beat : db_beat;
            ireq_tkeep_o <= 8'hFF;
            ireq_tlast_o <= (req_kind_i != REQ_NWR);
            ireq_tuser_o <= {src_id_i, des_id_i};
        end else if (user_take) begin
            ireq_tdata_o <= user_tdata_i;
            ireq_tkeep_o <= user_tkeep_i;
            ireq_tlast_o <= user_tlast_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/iresp_decoder.sv */
// Doorbell response decoder
// Classifies replies from the responder as READY, BUSY or
// integration confirm, and keeps the target-select bit

`timescale 1ns/1ps
`default_nettype none

`include "srio_db_config.svh"

module iresp_decoder
    import srio_pkt_pkg::*;
(
    input  wire logic       log_clk,
    input  wire logic       log_rst,

    input  wire logic       iresp_tvalid_i,
    input  wire beat_data_t iresp_tdata_i,
    input  wire beat_user_t iresp_tuser_i,

    output logic            resp_ready_o,
    output logic            resp_busy_o,
    output logic            resp_confirm_o,
    output logic            target_sel_o
);

    ftype_t   resp_ftype;
    db_info_t resp_info;
    dev_id_t  resp_src_id;
    db_info_t integ_info;
    logic     is_db_reply;
    logic     is_confirm;

    assign resp_ftype  = iresp_tdata_i[55:52];
    assign resp_info   = iresp_tdata_i[31:16];
    assign resp_src_id = iresp_tuser_i[31:16];

    // Info expected back for the integration doorbell in flight
    assign integ_info = `DB_INFO_INTEG_BASE + {15'h0000, ~target_sel_o};

    assign is_db_reply = iresp_tvalid_i && (resp_ftype == `SRIO_FTYPE_DOORB) &&
                         (resp_src_id == `DB_RESP_SRC_ID);
    assign is_confirm  = is_db_reply && (resp_info == integ_info);

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            resp_ready_o   <= 1'b0;
            resp_busy_o    <= 1'b0;
            resp_confirm_o <= 1'b0;
            target_sel_o   <= 1'b0;
        end else begin
            resp_ready_o   <= is_db_reply && (resp_info == `DB_INFO_READY);
            resp_busy_o    <= is_db_reply && (resp_info == `DB_INFO_BUSY);
            resp_confirm_o <= is_confirm;
            // Next packet goes to the other target
            if (is_confirm) begin
                target_sel_o <= ~target_sel_o;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/db_ctrl.sv */
// Transaction controller
// State machine for self-check and NWRITE with integration doorbell,
// response wait timer, status flags and timeout error reporting

`timescale 1ns/1ps
`default_nettype none

`include "srio_db_config.svh"

module db_ctrl
    import db_ctrl_pkg::*;
(
    input  wire logic  log_clk,
    input  wire logic  log_rst,

    input  wire logic  self_check_i,
    input  wire logic  nwr_req_i,
    input  wire logic  link_initialized_i,

    output logic       req_start_o,
    output req_kind_t  req_kind_o,
    input  wire logic  req_done_i,

    input  wire logic  resp_ready_i,
    input  wire logic  resp_busy_i,
    input  wire logic  resp_confirm_i,

    output logic       nwr_ready_o,
    output logic       nwr_busy_o,
    output logic       rapidio_ready_o,
    output logic       nwr_ack_done_o,
    output logic       error_o,
    output db_err_t    error_type_o
);

    localparam int unsigned TIMEOUT_LAST = `DB_TIMEOUT_CYCLES - 1;

    db_state_t               state_q;
    logic [`DB_TIMER_W-1:0]  timer_q;
    logic                    waiting;
    logic                    timeout;

    assign waiting = (state_q == DB_RESP) || (state_q == WAIT_ACK);
    assign timeout = waiting && (timer_q == TIMEOUT_LAST[`DB_TIMER_W-1:0]);

    // Busy while a packet is going out
    assign rapidio_ready_o = !((state_q == DB_REQ) || (state_q == NWR) ||
                               (state_q == INTEG_REQ));
    assign nwr_ack_done_o  = resp_confirm_i;

    // Runs only while a reply is awaited
    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            timer_q <= '0;
        end else if (waiting) begin
            timer_q <= timer_q + 1'b1;
        end else begin
            timer_q <= '0;
        end
    end

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            state_q      <= IDLE;
            req_start_o  <= 1'b0;
            req_kind_o   <= REQ_DB_SELF;
            nwr_ready_o  <= 1'b0;
            nwr_busy_o   <= 1'b0;
            error_o      <= 1'b0;
            error_type_o <= ERR_NONE;
        end else begin
            req_start_o <= 1'b0;
            error_o     <= 1'b0;
            case (state_q)
                IDLE: begin
                    // Self-check wins over NWR
                    if (link_initialized_i && self_check_i) begin
                        state_q     <= DB_REQ;
                        req_start_o <= 1'b1;
                        req_kind_o  <= REQ_DB_SELF;
                        nwr_ready_o <= 1'b0;
                        nwr_busy_o  <= 1'b0;
                    end else if (link_initialized_i && nwr_req_i) begin
                        state_q     <= NWR;
                        req_start_o <= 1'b1;
                        req_kind_o  <= REQ_NWR;
                        nwr_ready_o <= 1'b0;
                    end
                end
                DB_REQ: begin
                    if (req_done_i) begin
                        state_q <= DB_RESP;
                    end
                end
                DB_RESP: begin
                    if (resp_ready_i) begin
                        nwr_ready_o <= 1'b1;
                        state_q     <= IDLE;
                    end else if (resp_busy_i) begin
                        nwr_busy_o <= 1'b1;
                        state_q    <= IDLE;
                    end else if (timeout) begin
                        error_o      <= 1'b1;
                        error_type_o <= ERR_NO_DB_RESP;
                        state_q      <= IDLE;
                    end
                end
                NWR: begin
                    // Integration doorbell follows the last data beat
                    if (req_done_i) begin
                        state_q     <= INTEG_REQ;
                        req_start_o <= 1'b1;
                        req_kind_o  <= REQ_DB_INTEG;
                    end
                end
                INTEG_REQ: begin
                    if (req_done_i) begin
                        state_q <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (resp_confirm_i) begin
                        state_q <= IDLE;
                    end else if (timeout) begin
                        error_o      <= 1'b1;
                        error_type_o <= ERR_NO_INTEG_ACK;
                        state_q      <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/srio_db_req_top.sv */
// Top level of the SRIO request engine
// Connects the transaction controller, the request stream builder
// and the doorbell response decoder

`timescale 1ns/1ps
`default_nettype none

module srio_db_req_top
    import srio_pkt_pkg::*;
    import db_ctrl_pkg::*;
(
    input  wire logic       log_clk,
    input  wire logic       log_rst,

    input  wire dev_id_t    src_id_i,
    input  wire dev_id_t    des_id_i,
    input  wire logic       self_check_i,
    input  wire logic       nwr_req_i,
    input  wire nwr_size_t  nwr_size_i,
    input  wire logic       link_initialized_i,

    input  wire beat_data_t user_tdata_i,
    input  wire beat_keep_t user_tkeep_i,
    input  wire logic       user_tvalid_i,
    input  wire logic       user_tlast_i,
    output logic            user_tready_o,

    output logic            ireq_tvalid_o,
    input  wire logic       ireq_tready_i,
    output beat_data_t      ireq_tdata_o,
    output beat_keep_t      ireq_tkeep_o,
    output logic            ireq_tlast_o,
    output beat_user_t      ireq_tuser_o,

    input  wire logic       iresp_tvalid_i,
    input  wire beat_data_t iresp_tdata_i,
    input  wire beat_user_t iresp_tuser_i,

    output logic            nwr_ready_o,
    output logic            nwr_busy_o,
    output logic            rapidio_ready_o,
    output logic            nwr_ack_done_o,
    output logic            error_o,
    output db_err_t         error_type_o
);

    logic      req_start;
    req_kind_t req_kind;
    logic      req_done;
    logic      resp_ready;
    logic      resp_busy;
    logic      resp_confirm;
    logic      target_sel;

    db_ctrl u_db_ctrl (
        .log_clk            (log_clk),
        .log_rst            (log_rst),
        .self_check_i       (self_check_i),
        .nwr_req_i          (nwr_req_i),
        .link_initialized_i (link_initialized_i),
        .req_start_o        (req_start),
        .req_kind_o         (req_kind),
        .req_done_i         (req_done),
        .resp_ready_i       (resp_ready),
        .resp_busy_i        (resp_busy),
        .resp_confirm_i     (resp_confirm),
        .nwr_ready_o        (nwr_ready_o),
        .nwr_busy_o         (nwr_busy_o),
        .rapidio_ready_o    (rapidio_ready_o),
        .nwr_ack_done_o     (nwr_ack_done_o),
        .error_o            (error_o),
        .error_type_o       (error_type_o)
    );

    ireq_builder u_ireq_builder (
        .log_clk       (log_clk),
        .log_rst       (log_rst),
        .req_start_i   (req_start),
        .req_kind_i    (req_kind),
        .req_done_o    (req_done),
        .src_id_i      (src_id_i),
        .des_id_i      (des_id_i),
        .nwr_size_i    (nwr_size_i),
        .target_sel_i  (target_sel),
        .user_tdata_i  (user_tdata_i),
        .user_tkeep_i  (user_tkeep_i),
        .user_tvalid_i (user_tvalid_i),
        .user_tlast_i  (user_tlast_i),
        .user_tready_o (user_tready_o),
        .ireq_tvalid_o (ireq_tvalid_o),
        .ireq_tready_i (ireq_tready_i),
        .ireq_tdata_o  (ireq_tdata_o),
        .ireq_tkeep_o  (ireq_tkeep_o),
        .ireq_tlast_o  (ireq_tlast_o),
        .ireq_tuser_o  (ireq_tuser_o)
    );

    iresp_decoder u_iresp_decoder (
        .log_clk        (log_clk),
        .log_rst        (log_rst),
        .iresp_tvalid_i (iresp_tvalid_i),
        .iresp_tdata_i  (iresp_tdata_i),
        .iresp_tuser_i  (iresp_tuser_i),
        .resp_ready_o   (resp_ready),
        .resp_busy_o    (resp_busy),
        .resp_confirm_o (resp_confirm),
        .target_sel_o   (target_sel)
    );

endmodule

`default_nettype wire

/* dv/srio_db_req_sva.sv */
// Bound assertions for the SRIO request engine
// Request stream stability under stall, doorbell and NWRITE header
// fields, and the error code and pulse shape on a response timeout

`timescale 1ns/1ps
`default_nettype none

`include "srio_db_config.svh"

module srio_db_req_sva
    import srio_pkt_pkg::*;
    import db_ctrl_pkg::*;
(
    input  wire logic       log_clk,
    input  wire logic       log_rst,
    input  wire logic       ireq_tvalid_i,
    input  wire logic       ireq_tready_i,
    input  wire beat_data_t ireq_tdata_i,
    input  wire beat_keep_t ireq_tkeep_i,
    input  wire logic       ireq_tlast_i,
    input  wire beat_user_t ireq_tuser_i,
    input  wire logic       error_i,
    input  wire db_err_t    error_type_i
);

    logic first_beat;
    logic last_db_self;
    logic xfer;

    assign xfer = ireq_tvalid_i && ireq_tready_i;

    // Set while the next beat opens a packet
    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            first_beat   <= 1'b1;
            last_db_self <= 1'b0;
        end else if (xfer) begin
            first_beat <= ireq_tlast_i;
            // Remember which doorbell a timeout would belong to
            if (first_beat && ireq_tlast_i) begin
                last_db_self <= (ireq_tdata_i[31:16] == `DB_INFO_SELF);
            end
        end
    end

    a_hold_on_stall: assert property (@(posedge log_clk) disable iff (log_rst)
        ireq_tvalid_i && !ireq_tready_i |=>
            ireq_tvalid_i && $stable(ireq_tdata_i) && $stable(ireq_tkeep_i) &&
            $stable(ireq_tlast_i) && $stable(ireq_tuser_i))
        else $error("Request beat changed or dropped while stalled");

    // A single-beat packet is always a doorbell
    a_doorbell_fields: assert property (@(posedge log_clk) disable iff (log_rst)
        ireq_tvalid_i && first_beat && ireq_tlast_i |->
            ireq_tdata_i[55:52] == `SRIO_FTYPE_DOORB && ireq_tkeep_i == 8'hFF &&
            ireq_tdata_i[46:45] == `SRIO_REQ_PRIO &&
            ireq_tdata_i[31:16] inside {`DB_INFO_SELF, `DB_INFO_INTEG_BASE,
                                        (`DB_INFO_INTEG_BASE + 16'h0001)})
        else $error("Doorbell beat carries wrong fields");

    // TID bit 0 follows the target address
    a_nwr_header: assert property (@(posedge log_clk) disable iff (log_rst)
        ireq_tvalid_i && first_beat && !ireq_tlast_i |->
            ireq_tdata_i[55:52] == `SRIO_FTYPE_NWR &&
            ireq_tdata_i[51:48] == `SRIO_TTYPE_NWR &&
            ireq_tdata_i[46:45] == `SRIO_REQ_PRIO && ireq_tkeep_i == 8'hFF &&
            ireq_tdata_i[33:0] inside {34'h0, `TARGET_ADDR_STEP} &&
            ireq_tdata_i[56] == (ireq_tdata_i[33:0] == `TARGET_ADDR_STEP))
        else $error("NWRITE header carries wrong fields");

    // Self-check timeouts and integration timeouts carry their own codes
    a_error_code: assert property (@(posedge log_clk) disable iff (log_rst)
        error_i |->
            error_type_i == (last_db_self ? ERR_NO_DB_RESP : ERR_NO_INTEG_ACK))
        else $error("Error code does not match the unanswered doorbell");

    a_error_pulse: assert property (@(posedge log_clk) disable iff (log_rst)
        error_i |=> !error_i)
        else $error("Error output held longer than one cycle");

endmodule

`default_nettype wire

/* dv/tb_srio_db_req.sv */
// Testbench for the SRIO request engine
// Clock and reset, LFSR stalls and user stream, doorbell responder,
// self-check, NWRITE and timeout scenarios, watchdog and final report

`timescale 1ns/1ps
`default_nettype none

`include "srio_db_config.svh"

module tb_srio_db_req
    import srio_pkt_pkg::*;
    import db_ctrl_pkg::*;
();

    localparam int TIMEOUT         = `DB_TIMEOUT_CYCLES;
    localparam int WAIT_LIMIT      = 200;
    localparam int WATCHDOG_CYCLES = 4 * `DB_TIMEOUT_CYCLES + 1000;
    localparam int MODE_READY      = 0;
    localparam int MODE_BUSY       = 1;
    localparam int MODE_SILENT     = 2;
    localparam int FLAG_READY      = 0;
    localparam int FLAG_BUSY       = 1;
    localparam int FLAG_ERROR      = 2;
    localparam int FLAG_ACK        = 3;

    logic       log_clk;
    logic       log_rst;
    dev_id_t    src_id_i;
    dev_id_t    des_id_i;
    logic       self_check_i;
    logic       nwr_req_i;
    nwr_size_t  nwr_size_i;
    logic       link_initialized_i;
    beat_data_t user_tdata_i;
    beat_keep_t user_tkeep_i;
    logic       user_tvalid_i;
    logic       user_tlast_i;
    logic       user_tready_o;
    logic       ireq_tvalid_o;
    logic       ireq_tready_i;
    beat_data_t ireq_tdata_o;
    beat_keep_t ireq_tkeep_o;
    logic       ireq_tlast_o;
    beat_user_t ireq_tuser_o;
    logic       iresp_tvalid_i;
    beat_data_t iresp_tdata_i;
    beat_user_t iresp_tuser_i;
    logic       nwr_ready_o;
    logic       nwr_busy_o;
    logic       rapidio_ready_o;
    logic       nwr_ack_done_o;
    logic       error_o;
    db_err_t    error_type_o;

    logic [31:0] lfsr_q;
    beat_data_t  pay_data [0:63];
    beat_keep_t  pay_keep [0:63];
    int          pay_base;
    int          pay_len;
    int          send_idx;
    logic        user_en;
    logic        stall_en;
    logic        at_start;
    int          reply_mode;
    int          checks_done;
    logic [5:0]  reached;

    srio_db_req_top DUT (.*);

    bind srio_db_req_top srio_db_req_sva u_sva (
        .log_clk       (log_clk),
        .log_rst       (log_rst),
        .ireq_tvalid_i (ireq_tvalid_o),
        .ireq_tready_i (ireq_tready_i),
        .ireq_tdata_i  (ireq_tdata_o),
        .ireq_tkeep_i  (ireq_tkeep_o),
        .ireq_tlast_i  (ireq_tlast_o),
        .ireq_tuser_i  (ireq_tuser_o),
        .error_i       (error_o),
        .error_type_i  (error_type_o)
    );

    always #2 log_clk = ~log_clk;

    // Galois LFSR, one step for every bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first failing check");
    endtask

    task automatic compare_hex(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks_done++;
        assert (got == exp) else
            stop_on_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h",
                                      name, got, exp));
    endtask

    task automatic require_true(input logic cond, input string what);
        checks_done++;
        assert (cond) else stop_on_failure(what);
    endtask

    // Next beat accepted on the request stream
    task automatic wait_beat(output beat_data_t data, output beat_keep_t keep,
                             output logic last, output beat_user_t user);
        int n;
        n = 0;
        do begin
            @(posedge log_clk);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_on_failure("No request beat was accepted in time");
            end
        end while (!(ireq_tvalid_o && ireq_tready_i));
        data = ireq_tdata_o;
        keep = ireq_tkeep_o;
        last = ireq_tlast_o;
        user = ireq_tuser_o;
    endtask

    // Counts edges until the selected status output is seen high
    task automatic await_status(input int sel, input int limit, output int cycles);
        logic level;
        cycles = 0;
        level  = 1'b0;
        while (!level) begin
            @(posedge log_clk);
            cycles++;
            case (sel)
                FLAG_READY: level = nwr_ready_o;
                FLAG_BUSY:  level = nwr_busy_o;
                FLAG_ERROR: level = error_o;
                default:    level = nwr_ack_done_o;
            endcase
            if (!level && cycles >= limit) begin
                stop_on_failure($sformatf("Status output %0d never went high", sel));
            end
        end
    endtask

    task automatic pulse_request(input logic self_check);
        @(posedge log_clk);
        if (self_check) begin
            self_check_i <= 1'b1;
        end else begin
            nwr_req_i <= 1'b1;
        end
        @(posedge log_clk);
        self_check_i <= 1'b0;
        nwr_req_i    <= 1'b0;
    endtask

    task automatic issue_self_check();
        beat_data_t data;
        beat_keep_t keep;
        logic       last;
        beat_user_t user;
        pulse_request(1'b1);
        wait_beat(data, keep, last, user);
        compare_hex("rapidio_ready_o while sending", rapidio_ready_o, 1'b0);
        compare_hex("doorbell ftype", data[55:52], 4'hA);
        compare_hex("doorbell info", data[31:16], 16'h0101);
        compare_hex("doorbell tkeep", keep, 8'hFF);
        compare_hex("doorbell tlast", last, 1'b1);
        compare_hex("doorbell tuser", user, {src_id_i, des_id_i});
    endtask

    // Header, user beats in order, then the integration doorbell
    task automatic send_nwrite(input int base, input int len, input logic target);
        beat_data_t data;
        beat_keep_t keep;
        logic       last;
        beat_user_t user;
        @(posedge log_clk);
        pay_base   <= base;
        pay_len    <= len;
        send_idx   <= 0;
        user_en    <= 1'b1;
        nwr_size_i <= nwr_size_t'(len * 8 - 1);
        pulse_request(1'b0);
        wait_beat(data, keep, last, user);
        compare_hex("header tid", data[63:56], {7'h00, target});
        compare_hex("header ftype", data[55:52], 4'h5);
        compare_hex("header ttype", data[51:48], 4'h4);
        compare_hex("header size", data[43:36], len * 8 - 1);
        compare_hex("header address", data[33:0], target ? 34'h10_0000 : 34'h0);
        compare_hex("header tlast", last, 1'b0);
        compare_hex("header tuser", user, {src_id_i, des_id_i});
        for (int i = 0; i < len; i++) begin
            wait_beat(data, keep, last, user);
            compare_hex("data beat", data, pay_data[base + i]);
            compare_hex("data tkeep", keep, pay_keep[base + i]);
            compare_hex("data tlast", last, i == len - 1);
        end
        wait_beat(data, keep, last, user);
        compare_hex("integration ftype", data[55:52], 4'hA);
        compare_hex("integration info", data[31:16], target ? 16'h0200 : 16'h0201);
        compare_hex("integration tlast", last, 1'b1);
        user_en <= 1'b0;
    endtask

    // Sink stalls and the user stream source
    always @(posedge log_clk) begin
        int idx;
        idx = send_idx;
        if (user_tvalid_i && user_tready_o) begin
            idx = idx + 1;
            send_idx <= idx;
        end
        ireq_tready_i <= stall_en ? (take_bits(2) != 0) : 1'b1;
        // An offered beat stays until it is taken
        if (!user_tvalid_i || user_tready_o) begin
            if (user_en && idx < pay_len && take_bits(1) != 0) begin
                user_tvalid_i <= 1'b1;
                user_tdata_i  <= pay_data[pay_base + idx];
                user_tkeep_i  <= pay_keep[pay_base + idx];
                user_tlast_i  <= (idx == pay_len - 1);
            end else begin
                user_tvalid_i <= 1'b0;
            end
        end
    end

    // Responder: self-check gets READY or BUSY, integration info is echoed
    always @(posedge log_clk) begin
        db_info_t info;
        info = ireq_tdata_o[31:16];
        if (info == `DB_INFO_SELF) begin
            info = (reply_mode == MODE_BUSY) ? `DB_INFO_BUSY : `DB_INFO_READY;
        end
        iresp_tvalid_i <= 1'b0;
        if (ireq_tvalid_o && ireq_tready_i) begin
            at_start <= ireq_tlast_o;
            if (at_start && ireq_tlast_o && reply_mode != MODE_SILENT) begin
                iresp_tvalid_i <= 1'b1;
                iresp_tdata_i  <= {8'h00, `SRIO_FTYPE_DOORB, 20'h00000, info, 16'h0000};
                iresp_tuser_i  <= {`DB_RESP_SRC_ID, src_id_i};
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge log_clk);
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $fatal(1, "Watchdog timeout");
    end

    initial begin
        int waited;
        log_clk            = 1'b0;
        log_rst            = 1'b1;
        src_id_i           = 16'h0011;
        des_id_i           = 16'h00F0;
        self_check_i       = 1'b0;
        nwr_req_i          = 1'b0;
        nwr_size_i         = '0;
        link_initialized_i = 1'b0;
        user_tdata_i       = '0;
        user_tkeep_i       = '0;
        user_tvalid_i      = 1'b0;
        user_tlast_i       = 1'b0;
        ireq_tready_i      = 1'b0;
        iresp_tvalid_i     = 1'b0;
        iresp_tdata_i      = '0;
        iresp_tuser_i      = '0;
        pay_base           = 0;
        pay_len            = 0;
        send_idx           = 0;
        user_en            = 1'b0;
        stall_en           = 1'b0;
        at_start           = 1'b1;
        reply_mode         = MODE_READY;
        checks_done        = 0;
        reached            = '0;
        lfsr_q             = 32'h598f;
        for (int i = 0; i < 64; i++) begin
            pay_data[i] = take_bits(64);
            pay_keep[i] = take_bits(8);
        end

        repeat (16) @(posedge log_clk);
        log_rst            <= 1'b0;
        link_initialized_i <= 1'b1;
        @(posedge log_clk);
        compare_hex("ireq_tvalid_o after reset", ireq_tvalid_o, 1'b0);
        compare_hex("user_tready_o after reset", user_tready_o, 1'b0);
        compare_hex("error_o after reset", error_o, 1'b0);
        compare_hex("error_type_o after reset", error_type_o, ERR_NONE);
        compare_hex("rapidio_ready_o after reset", rapidio_ready_o, 1'b1);
        compare_hex("nwr_ready_o after reset", nwr_ready_o, 1'b0);
        compare_hex("nwr_busy_o after reset", nwr_busy_o, 1'b0);
        compare_hex("nwr_ack_done_o after reset", nwr_ack_done_o, 1'b0);

        issue_self_check();
        await_status(FLAG_READY, WAIT_LIMIT, waited);
        compare_hex("rapidio_ready_o after READY", rapidio_ready_o, 1'b1);
        reached[0] = 1'b1;

        reply_mode <= MODE_BUSY;
        issue_self_check();
        await_status(FLAG_BUSY, WAIT_LIMIT, waited);
        compare_hex("nwr_ready_o after BUSY", nwr_ready_o, 1'b0);
        reached[1] = 1'b1;

        // Error register is set TIMEOUT edges after entering the wait, seen one edge later
        reply_mode <= MODE_SILENT;
        issue_self_check();
        await_status(FLAG_ERROR, TIMEOUT + WAIT_LIMIT, waited);
        compare_hex("doorbell timeout cycles", waited, TIMEOUT + 1);
        compare_hex("error_type_o", error_type_o, ERR_NO_DB_RESP);
        compare_hex("nwr_busy_o after new self-check", nwr_busy_o, 1'b0);
        @(posedge log_clk);
        require_true(!error_o, "error_o stayed high after its pulse");
        reached[2] = 1'b1;

        stall_en   <= 1'b1;
        reply_mode <= MODE_READY;
        send_nwrite(0, 12, 1'b0);
        reached[3] = 1'b1;
        await_status(FLAG_ACK, WAIT_LIMIT, waited);
        send_nwrite(32, 8, 1'b1);
        await_status(FLAG_ACK, WAIT_LIMIT, waited);
        reached[4] = 1'b1;

        reply_mode <= MODE_SILENT;
        send_nwrite(48, 3, 1'b0);
        await_status(FLAG_ERROR, TIMEOUT + WAIT_LIMIT, waited);
        compare_hex("error_type_o", error_type_o, ERR_NO_INTEG_ACK);
        reached[5] = 1'b1;

        @(posedge log_clk);
        $display("Checks reached: %0d", checks_done);
        if (reached == 6'h3F) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Not every scenario was exercised");
            $display("Some tests failed");
            $fatal(1, "Incomplete run");
        end
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/srio_pkt_pkg.sv
rtl/db_ctrl_pkg.sv
rtl/ireq_builder.sv
rtl/iresp_decoder.sv
rtl/db_ctrl.sv
rtl/srio_db_req_top.sv
dv/srio_db_req_sva.sv
dv/tb_srio_db_req.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_srio_db_req \
    -f files.f -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0
